//--- arb_result_if.sv
// Arbitration result of one replica, carried to the output voters
`timescale 1ns/100ps

interface arb_result_if;

  import rr_arb_pkg::*;

  // Grant vector towards the requesters, already qualified by gnt_i
  req_vec_t gnt;

  // High when at least one effective request is present
  logic     req;

  // Index of the requester that wins the tree
  idx_t     idx;

  // Payload of the winning requester
  data_t    data;

  // The replica produces the whole result
  modport replica (
    output gnt,
    output req,
    output idx,
    output data
  );

  // The top-level voters only read it
  modport voter (
    input gnt,
    input req,
    input idx,
    input data
  );

endinterface

//--- rr_arb_config.svh
// Build-time sizes for the redundant round-robin arbitration tree
`ifndef RR_ARB_CONFIG_SVH
`define RR_ARB_CONFIG_SVH

// Number of requesters sharing the downstream port
// Must be a power of two, so every tree level is full
`define RR_ARB_NUM_IN 8

// Payload width in bits for every requester
`define RR_ARB_DATA_WIDTH 16

// Number of redundant arbiter replicas
// The voters are two-out-of-three, so this stays at three
`define RR_ARB_NUM_COPIES 3

`endif

//--- rr_arb_pkg.sv
// Shared types for the redundant round-robin arbitration tree
`include "rr_arb_config.svh"

package rr_arb_pkg;

  // Sizes taken from the configuration header
  localparam int unsigned NUM_IN     = `RR_ARB_NUM_IN;
  localparam int unsigned DATA_WIDTH = `RR_ARB_DATA_WIDTH;

  // One index bit per tree level, the top bit belongs to the root
  localparam int unsigned IDX_WIDTH  = $clog2(NUM_IN);

  // Requester index, also used as the round-robin priority pointer
  typedef logic [IDX_WIDTH-1:0] idx_t;

  // Payload carried from each requester to the downstream port
  typedef logic [DATA_WIDTH-1:0] data_t;

  // One bit per requester, used for requests and grants alike
  typedef logic [NUM_IN-1:0] req_vec_t;

  // State of the lock-in register
  // While held, the arbiter works on the captured request vector
  typedef enum logic {
    LOCK_FREE = 1'b0,
    LOCK_HELD = 1'b1
  } lock_state_e;

endpackage

//--- rr_arb_replica.sv
// One redundant copy of the round-robin arbiter with its voted lock and priority state
`timescale 1ns/100ps

module rr_arb_replica (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  input  rr_arb_pkg::req_vec_t             req_i,
  input  rr_arb_pkg::data_t [rr_arb_pkg::NUM_IN-1:0] data_i,
  input  logic                             gnt_i,
  arb_result_if.replica                    result,
  output rr_arb_pkg::lock_state_e          lock_prop_o,
  output rr_arb_pkg::req_vec_t             req_prop_o,
  output rr_arb_pkg::idx_t                 prio_prop_o,
  input  rr_arb_pkg::lock_state_e [1:0]    lock_peer_i,
  input  rr_arb_pkg::req_vec_t [1:0]       req_peer_i,
  input  rr_arb_pkg::idx_t [1:0]           prio_peer_i,
  output logic                             fault_o
);

  import rr_arb_pkg::*;

  // The requesters are the leaves, so the full binary tree has NUM_IN-1 selector nodes
  // Node 0 is the root
  localparam int unsigned NUM_NODES = NUM_IN - 1;

  // Registered state and its proposed next values
  lock_state_e lock_q, lock_d;
  req_vec_t    req_q;
  idx_t        prio_q, prio_d;

  // Majority of own and peer proposals, as loaded into the registers
  logic        lock_voted;
  req_vec_t    req_voted;
  idx_t        prio_voted;
  logic        lock_mm, req_mm, prio_mm;

  // Requests the tree works on, and the fair next pointer
  req_vec_t    req_eff;
  idx_t        next_idx;
  req_vec_t    gnt_vec;

  // Tree nodes, leaf-level nodes sit right above the requesters
  logic  [NUM_NODES-1:0] req_nodes;
  logic  [NUM_NODES-1:0] gnt_nodes;
  idx_t  [NUM_NODES-1:0] idx_nodes;
  data_t [NUM_NODES-1:0] data_nodes;

  //////////////////////////////////////////////////////////////////////
  // Lock-in and priority state
  //////////////////////////////////////////////////////////////////////

  // While held, the captured vector keeps the same winner in front
  assign req_eff = (lock_q == LOCK_HELD) ? req_q : req_i;

  // A request that the downstream side does not take locks the decision
  assign lock_d = (req_nodes[0] && !gnt_i) ? LOCK_HELD : LOCK_FREE;

  // The pointer only moves on a completed transfer
  assign prio_d = (req_nodes[0] && gnt_i) ? next_idx : prio_q;

  rr_next_prio u_next_prio (
    .req_i  (req_eff),
    .prio_i (prio_q),
    .next_o (next_idx)
  );

  // Proposals go out to the peers before the registers
  assign lock_prop_o = lock_d;
  assign req_prop_o  = req_eff;
  assign prio_prop_o = prio_d;

  // Each register loads what at least two of the three replicas propose
  tmr_voter #(.WIDTH(1)) u_lock_vote (
    .a_i        (lock_d),
    .b_i        (lock_peer_i[0]),
    .c_i        (lock_peer_i[1]),
    .majority_o (lock_voted),
    .mismatch_o (lock_mm)
  );

  tmr_voter #(.WIDTH(NUM_IN)) u_req_vote (
    .a_i        (req_eff),
    .b_i        (req_peer_i[0]),
    .c_i        (req_peer_i[1]),
    .majority_o (req_voted),
    .mismatch_o (req_mm)
  );

  tmr_voter #(.WIDTH(IDX_WIDTH)) u_prio_vote (
    .a_i        (prio_d),
    .b_i        (prio_peer_i[0]),
    .c_i        (prio_peer_i[1]),
    .majority_o (prio_voted),
    .mismatch_o (prio_mm)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= LOCK_FREE;
      req_q  <= '0;
      prio_q <= '0;
    end else if (flush_i) begin
      lock_q <= LOCK_FREE;
      req_q  <= '0;
      prio_q <= '0;
    end else begin
      lock_q <= lock_state_e'(lock_voted);
      req_q  <= req_voted;
      prio_q <= prio_voted;
    end
  end

  // Any disagreement on the state of this replica
  assign fault_o = lock_mm | req_mm | prio_mm;

  //////////////////////////////////////////////////////////////////////
  // Arbitration tree
  //////////////////////////////////////////////////////////////////////

  // The downstream acceptance enters at the root
  assign gnt_nodes[0] = gnt_i;

  for (genvar level = 0; level < IDX_WIDTH; level++) begin : gen_level
    for (genvar n = 0; n < 2 ** level; n++) begin : gen_node
      localparam int unsigned NODE  = 2 ** level - 1 + n;
      localparam int unsigned CHILD = 2 ** (level + 1) - 1 + 2 * n;
      localparam int unsigned PBIT  = IDX_WIDTH - 1 - level;
      // High when the upper child wins this node
      logic sel;

      if (level == IDX_WIDTH - 1) begin : gen_leaf
        // Leaf nodes choose between two neighbouring requesters
        assign sel = ~req_eff[2*n] | (req_eff[2*n+1] & prio_q[PBIT]);
        assign req_nodes[NODE]  = req_eff[2*n] | req_eff[2*n+1];
        assign idx_nodes[NODE]  = idx_t'(sel);
        assign data_nodes[NODE] = sel ? data_i[2*n+1] : data_i[2*n];
        // Grants are qualified by the request itself
        assign gnt_vec[2*n]   = gnt_nodes[NODE] & req_eff[2*n] & ~sel;
        assign gnt_vec[2*n+1] = gnt_nodes[NODE] & req_eff[2*n+1] & sel;
      end else begin : gen_inner
        assign sel = ~req_nodes[CHILD] | (req_nodes[CHILD+1] & prio_q[PBIT]);
        assign req_nodes[NODE] = req_nodes[CHILD] | req_nodes[CHILD+1];
        // The upper child adds this level's index bit on top of its own
        assign idx_nodes[NODE] = sel ?
          (idx_nodes[CHILD+1] | idx_t'(1 << PBIT)) : idx_nodes[CHILD];
        assign data_nodes[NODE]    = sel ? data_nodes[CHILD+1] : data_nodes[CHILD];
        assign gnt_nodes[CHILD]    = gnt_nodes[NODE] & ~sel;
        assign gnt_nodes[CHILD+1]  = gnt_nodes[NODE] & sel;
      end
    end
  end

  // Leaf-level grant nodes feed the requesters directly, the root gives the result
  assign result.gnt  = gnt_vec;
  assign result.req  = req_nodes[0];
  assign result.idx  = idx_nodes[0];
  assign result.data = data_nodes[0];

endmodule

//--- rr_next_prio.sv
// Fair next-priority computation from an upper and a lower trailing-zero search
`timescale 1ns/100ps

module rr_next_prio (
  input  rr_arb_pkg::req_vec_t req_i,
  input  rr_arb_pkg::idx_t     prio_i,
  output rr_arb_pkg::idx_t     next_o
);

  import rr_arb_pkg::*;

  // Requests strictly above the pointer, and at or below it
  req_vec_t upper_mask;
  req_vec_t lower_mask;

  // Lowest set bit of each group
  idx_t     upper_idx;
  idx_t     lower_idx;
  logic     upper_empty;

  // Returns the position of the lowest set bit, zero for an empty vector
  function automatic idx_t find_lowest(input req_vec_t vec);
    idx_t pos;
    pos = '0;
    // Scan downwards so the last hit is the lowest one
    for (int i = NUM_IN - 1; i >= 0; i--) begin
      if (vec[i]) begin
        pos = idx_t'(i);
      end
    end
    return pos;
  endfunction

  // Split the requests at the current pointer
  always_comb begin
    for (int i = 0; i < NUM_IN; i++) begin
      upper_mask[i] = (i > int'(prio_i)) ? req_i[i] : 1'b0;
      lower_mask[i] = (i <= int'(prio_i)) ? req_i[i] : 1'b0;
    end
  end

  assign upper_idx   = find_lowest(upper_mask);
  assign lower_idx   = find_lowest(lower_mask);
  assign upper_empty = ~|upper_mask;

  // Prefer the next waiting requester above the pointer
  // Otherwise wrap around to the lowest one at or below it
  assign next_o = upper_empty ? lower_idx : upper_idx;

endmodule

//--- tb_clock_gen.sv
// Testbench clock and power-on reset generator for the arbitration tree
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 100,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  // Free-running clock, the first rising edge comes half a period in
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset is released on a falling edge, well away from the register updates
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- tmr_rr_arb_tree.f
+incdir+.
rr_arb_pkg.sv
arb_result_if.sv
tmr_voter.sv
rr_next_prio.sv
rr_arb_replica.sv
tmr_rr_arb_tree.sv
tb_clock_gen.sv
tmr_rr_arb_tree_tb.sv

//--- tmr_rr_arb_tree.sv
// Triple-redundant round-robin arbitration tree with voted outputs and a fault flag
`timescale 1ns/100ps
`include "rr_arb_config.svh"

module tmr_rr_arb_tree (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       flush_i,
  input  rr_arb_pkg::req_vec_t                       req_i,
  input  rr_arb_pkg::data_t [rr_arb_pkg::NUM_IN-1:0] data_i,
  input  logic                                       gnt_i,
  output rr_arb_pkg::req_vec_t                       gnt_o,
  output logic                                       req_o,
  output rr_arb_pkg::idx_t                           idx_o,
  output rr_arb_pkg::data_t                          data_o,
  output logic                                       fault_o
);

  import rr_arb_pkg::*;

  localparam int unsigned NC = `RR_ARB_NUM_COPIES;

  // Next-state proposals of each replica
  lock_state_e [NC-1:0] lock_prop;
  req_vec_t    [NC-1:0] req_prop;
  idx_t        [NC-1:0] prio_prop;

  // The two peer proposals seen by each replica
  lock_state_e [NC-1:0][1:0] lock_peer;
  req_vec_t    [NC-1:0][1:0] req_peer;
  idx_t        [NC-1:0][1:0] prio_peer;

  // Mismatch flags of the replicas and of the output voters
  logic [NC-1:0] replica_fault;
  logic [3:0]    out_mm;

  arb_result_if res_if [NC] ();

  //////////////////////////////////////////////////////////////////////
  // Replicas
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NC; i++) begin : gen_replica
    // Ring wiring, replica i sees replicas i+1 and i+2
    for (genvar j = 0; j < 2; j++) begin : gen_peer
      assign lock_peer[i][j] = lock_prop[(i + j + 1) % NC];
      assign req_peer[i][j]  = req_prop[(i + j + 1) % NC];
      assign prio_peer[i][j] = prio_prop[(i + j + 1) % NC];
    end

    rr_arb_replica u_replica (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .flush_i     (flush_i),
      .req_i       (req_i),
      .data_i      (data_i),
      .gnt_i       (gnt_i),
      .result      (res_if[i]),
      .lock_prop_o (lock_prop[i]),
      .req_prop_o  (req_prop[i]),
      .prio_prop_o (prio_prop[i]),
      .lock_peer_i (lock_peer[i]),
      .req_peer_i  (req_peer[i]),
      .prio_peer_i (prio_peer[i]),
      .fault_o     (replica_fault[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Output voting
  //////////////////////////////////////////////////////////////////////

  tmr_voter #(.WIDTH(NUM_IN)) u_gnt_vote (
    .a_i (res_if[0].gnt), .b_i (res_if[1].gnt), .c_i (res_if[2].gnt),
    .majority_o (gnt_o),
    .mismatch_o (out_mm[0])
  );

  tmr_voter #(.WIDTH(1)) u_req_vote (
    .a_i (res_if[0].req), .b_i (res_if[1].req), .c_i (res_if[2].req),
    .majority_o (req_o),
    .mismatch_o (out_mm[1])
  );

  tmr_voter #(.WIDTH(IDX_WIDTH)) u_idx_vote (
    .a_i (res_if[0].idx), .b_i (res_if[1].idx), .c_i (res_if[2].idx),
    .majority_o (idx_o),
    .mismatch_o (out_mm[2])
  );

  tmr_voter #(.WIDTH(DATA_WIDTH)) u_data_vote (
    .a_i (res_if[0].data), .b_i (res_if[1].data), .c_i (res_if[2].data),
    .majority_o (data_o),
    .mismatch_o (out_mm[3])
  );

  // Any disagreement, in the state or on the outputs, is reported
  assign fault_o = |replica_fault | |out_mm;

endmodule

//--- tmr_rr_arb_tree_stim.txt
# Columns: test flush req_i(hex) gnt_i expected_req_o expected_idx_o
# One line per clock cycle, expected_idx_o is ignored while expected_req_o is 0
1 0 00 1 0 0
1 0 00 0 0 0
1 0 00 1 0 0
2 0 ff 1 1 0
2 0 ff 1 1 1
2 0 ff 1 1 2
2 0 ff 1 1 3
2 0 ff 1 1 4
2 0 ff 1 1 5
2 0 ff 1 1 6
2 0 ff 1 1 7
2 0 ff 1 1 0
3 0 a4 1 1 2
3 0 a4 1 1 2
3 0 a4 1 1 5
3 0 a4 1 1 7
3 0 a4 1 1 2
3 0 a4 1 1 5
3 0 12 1 1 4
3 0 12 1 1 1
3 0 12 1 1 4
3 0 12 1 1 1
4 0 6a 0 1 5
4 0 6a 0 1 5
4 0 6a 0 1 5
4 0 6a 1 1 5
4 0 6a 1 1 5
4 0 6a 1 1 6
4 0 6a 1 1 1
4 0 6a 0 1 3
4 0 6a 0 1 3
4 0 6a 1 1 3
5 0 ff 0 1 5
5 1 ff 0 1 5
5 0 ff 1 1 0
5 0 ff 1 1 1
5 1 00 0 0 0
5 0 ff 1 1 0
6 0 00 1 0 0
6 0 00 0 0 0
6 0 80 1 1 7
6 0 01 1 1 0
6 0 00 1 0 0

//--- tmr_rr_arb_tree_tb.sv
// Testbench for the redundant round-robin arbitration tree, driven from a stimulus file
`timescale 1ns/100ps

module tmr_rr_arb_tree_tb;

  import rr_arb_pkg::*;

  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned DRIVE_DELAY  = 1;
  // Outputs are sampled 2 ns before the next rising edge
  localparam int unsigned SETTLE_TIME  = CLK_PERIOD - DRIVE_DELAY - 2;
  localparam string       STIM_FILE    = "tmr_rr_arb_tree_stim.txt";
  localparam logic [31:0] SEED         = 32'h5e59_1755;

  logic                  clk;
  logic                  rst_n;
  logic                  flush;
  req_vec_t              req;
  data_t [NUM_IN-1:0]    data;
  logic                  dn_gnt;
  req_vec_t              gnt;
  logic                  req_out;
  idx_t                  idx;
  data_t                 data_out;
  logic                  fault;

  // One entry per stimulus line
  int       test_q[$];
  bit       flush_q[$];
  req_vec_t req_vec_q[$];
  bit       gnt_q[$];
  bit       exp_req_q[$];
  int       exp_idx_q[$];

  int       num_vec;
  bit       stim_loaded;
  int       err_count;
  int       check_count;
  int       test_count;
  int       cur_test;
  int       test_cycles;
  int       test_err_base;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tmr_rr_arb_tree dut0 (
    .clk_i   (clk),
    .rst_ni  (rst_n),
    .flush_i (flush),
    .req_i   (req),
    .data_i  (data),
    .gnt_i   (dn_gnt),
    .gnt_o   (gnt),
    .req_o   (req_out),
    .idx_o   (idx),
    .data_o  (data_out),
    .fault_o (fault)
  );

  //////////////////////////////////////////////////////////////////////
  // Stimulus loading
  //////////////////////////////////////////////////////////////////////

  // Lines starting with # and empty lines are skipped
  task automatic load_stimulus(output bit ok);
    int       fd;
    int       n;
    int       t, f, g, er, ei;
    req_vec_t r;
    string    line;
    ok = 1'b1;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%d %d %h %d %d %d", t, f, r, g, er, ei);
          if (n != 6) begin
            $display("Malformed line in the stimulus file: %s", line);
            ok = 1'b0;
          end else begin
            test_q.push_back(t);
            flush_q.push_back(f[0]);
            req_vec_q.push_back(r);
            gnt_q.push_back(g[0]);
            exp_req_q.push_back(er[0]);
            exp_idx_q.push_back(ei);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checking and reporting
  //////////////////////////////////////////////////////////////////////

  task automatic note_error(input string msg);
    $display("[ERROR] %t: %s", $time, msg);
    err_count++;
  endtask

  // Fresh payloads for every test, held steady while the test runs
  task automatic start_test(input int num);
    cur_test      = num;
    test_cycles   = 0;
    test_err_base = err_count;
    test_count++;
    for (int i = 0; i < NUM_IN; i++) begin
      data[i] = data_t'($urandom);
    end
  endtask

  task automatic close_test();
    $display("Test %0d: %0d cycles, %0d errors, %s", cur_test, test_cycles,
             err_count - test_err_base, (err_count == test_err_base) ? "PASS" : "FAIL");
  endtask

  // The grant is one-hot on the winner, and only while the downstream side accepts
  task automatic check_outputs(input int k);
    req_vec_t exp_gnt;
    exp_gnt = '0;
    if (exp_req_q[k] && gnt_q[k]) begin
      exp_gnt[exp_idx_q[k]] = 1'b1;
    end
    check_count++;
    test_cycles++;
    if (req_out !== exp_req_q[k]) begin
      note_error($sformatf("test %0d line %0d: req_o = %b, expected %b",
                           test_q[k], k, req_out, exp_req_q[k]));
    end
    if (gnt !== exp_gnt) begin
      note_error($sformatf("test %0d line %0d: gnt_o = %b, expected %b",
                           test_q[k], k, gnt, exp_gnt));
    end
    if (exp_req_q[k] && idx !== idx_t'(exp_idx_q[k])) begin
      note_error($sformatf("test %0d line %0d: idx_o = %0d, expected %0d",
                           test_q[k], k, idx, exp_idx_q[k]));
    end
    if (exp_req_q[k] && data_out !== data[exp_idx_q[k]]) begin
      note_error($sformatf("test %0d line %0d: data_o = %h, expected %h",
                           test_q[k], k, data_out, data[exp_idx_q[k]]));
    end
    if (fault !== 1'b0) begin
      note_error($sformatf("test %0d line %0d: fault_o is set", test_q[k], k));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    bit      ok;
    $timeformat(-9, 1, " ns", 0);
    void'($urandom(SEED));
    flush       = 1'b0;
    req         = '0;
    data        = '0;
    dn_gnt      = 1'b0;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    cur_test    = -1;
    load_stimulus(ok);
    num_vec     = test_q.size();
    stim_loaded = 1'b1;
    if (!ok) begin
      $display("The stimulus could not be loaded, no test was run");
      $display("Verification failed");
      $finish;
    end else begin
      @(posedge rst_n);
      foreach (test_q[i]) begin
        @(posedge clk);
        #(DRIVE_DELAY);
        if (test_q[i] != cur_test) begin
          if (cur_test >= 0) begin
            close_test();
          end
          start_test(test_q[i]);
        end
        flush  = flush_q[i];
        req    = req_vec_q[i];
        dn_gnt = gnt_q[i];
        #(SETTLE_TIME);
        check_outputs(i);
      end
      close_test();
      $display("Summary: %0d tests, %0d cycles checked, %0d errors",
               test_count, check_count, err_count);
      if (err_count == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

  // Two clock periods per stimulus line and reset cycle leave ample margin
  initial begin
    wait (stim_loaded);
    #((num_vec + RESET_CYCLES) * 2 * CLK_PERIOD);
    $display("Watchdog expired before all stimulus lines were applied");
    $display("Verification failed");
    $finish;
  end

endmodule

//--- tmr_voter.sv
// Bitwise two-out-of-three majority voter with a disagreement flag
`timescale 1ns/100ps

module tmr_voter #(
  parameter int unsigned WIDTH = 1
) (
  input  logic [WIDTH-1:0] a_i,
  input  logic [WIDTH-1:0] b_i,
  input  logic [WIDTH-1:0] c_i,
  output logic [WIDTH-1:0] majority_o,
  output logic             mismatch_o
);

  // Per-bit disagreement between the three copies
  logic [WIDTH-1:0] diff;

  // Each output bit follows at least two of the three inputs
  assign majority_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  // A bit disagrees when any copy differs from the first one
  // Comparing a against b and c covers the b versus c case too
  assign diff = (a_i ^ b_i) | (a_i ^ c_i);

  // One flag for the whole word, the majority itself stays valid
  assign mismatch_o = |diff;

endmodule
